// ==== hdl/fec_defines.svh ====
`ifndef FEC_DEFINES_SVH
`define FEC_DEFINES_SVH

// ========================================
// Reed-Solomon code geometry, GF(16)
// ========================================

// Bits per symbol
`define FEC_SYM_SIZE 4

// Data symbols per codeword
`define FEC_RS_K 11

// Parity symbols per codeword
`define FEC_RS_2T 4

// Symbols per codeword is K + 2T
`define FEC_RS_N 15

// Wide enough to address every symbol
// Location 15 means no symbol
`define FEC_LOC_WID 4

// ========================================
// Derived widths
// ========================================

// Data word carried per beat
`define FEC_DATA_WID (`FEC_RS_K * `FEC_SYM_SIZE)

// Parity word appended by the encoder
`define FEC_PARITY_WID (`FEC_RS_2T * `FEC_SYM_SIZE)

`endif

// ==== hdl/fec_pkg.sv ====
`include "fec_defines.svh"

package fec_pkg;

    // ========================================
    // Codeword layout
    // ========================================

    // Symbol i is the coefficient of x^i
    // Parity sits in symbols 0..3, data in symbols 4..14
    typedef union packed {
        logic [`FEC_RS_N-1:0][`FEC_SYM_SIZE-1:0] symbols;
        struct packed {
            logic [`FEC_DATA_WID-1:0]   data;
            logic [`FEC_PARITY_WID-1:0] parity;
        } fields;
    } fec_codeword_u;

    // ========================================
    // Field constants
    // ========================================

    // x^4 folds back to x + 1
    localparam logic [`FEC_SYM_SIZE-1:0] GF_POLY_LOW = 4'h3;

    // Generator (x+1)(x+a)(x+a^2)(x+a^3) without its leading x^4 term
    // Index i holds the coefficient of x^i
    localparam logic [`FEC_RS_2T-1:0][`FEC_SYM_SIZE-1:0] RS_GEN = {4'd15, 4'd3, 4'd1, 4'd12};

    // ========================================
    // Arithmetic
    // ========================================

    // Shift-and-add multiply, reducing by x^4 + x + 1 on every shift
    function automatic logic [`FEC_SYM_SIZE-1:0] gf_mul(
        input logic [`FEC_SYM_SIZE-1:0] a,
        input logic [`FEC_SYM_SIZE-1:0] b
    );
        logic [`FEC_SYM_SIZE-1:0] acc;
        logic [`FEC_SYM_SIZE-1:0] sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < `FEC_SYM_SIZE; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = {sh[`FEC_SYM_SIZE-2:0], 1'b0} ^ (sh[`FEC_SYM_SIZE-1] ? GF_POLY_LOW : '0);
        end
        return acc;
    endfunction

    // Remainder of data(x) * x^4 divided by the generator
    // Same recurrence as a serial LFSR, unrolled, highest data symbol first
    function automatic logic [`FEC_PARITY_WID-1:0] rs_parity(
        input logic [`FEC_DATA_WID-1:0] data
    );
        logic [`FEC_RS_2T-1:0][`FEC_SYM_SIZE-1:0] rem;
        logic [`FEC_SYM_SIZE-1:0]                 fb;
        rem = '0;
        for (int j = `FEC_RS_K - 1; j >= 0; j--) begin
            fb = data[j*`FEC_SYM_SIZE +: `FEC_SYM_SIZE] ^ rem[`FEC_RS_2T-1];
            for (int i = `FEC_RS_2T - 1; i > 0; i--) begin
                rem[i] = rem[i-1] ^ gf_mul(fb, RS_GEN[i]);
            end
            rem[0] = gf_mul(fb, RS_GEN[0]);
        end
        return rem;
    endfunction

endpackage

// ==== hdl/fec_encode.sv ====
`include "fec_defines.svh"

module fec_encode
    import fec_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,

    input  logic [`FEC_DATA_WID-1:0]   data_in,
    input  logic [`FEC_LOC_WID-1:0]    err_loc_in,
    input  logic [`FEC_SYM_SIZE-1:0]   err_val_in,
    input  logic                       data_in_valid,
    output logic                       data_in_ready,

    output fec_codeword_u              codeword_out,
    output logic [`FEC_LOC_WID-1:0]    err_loc_out,
    output logic [`FEC_SYM_SIZE-1:0]   err_val_out,
    output logic                       data_out_valid,
    input  logic                       data_out_ready
);

    // ========================================
    // Systematic codeword
    // ========================================

    fec_codeword_u codeword_d;

    always_comb begin
        codeword_d.fields.data   = data_in;
        codeword_d.fields.parity = rs_parity(data_in);
    end

    // ========================================
    // Output register
    // ========================================

    // Empty or draining this cycle
    assign data_in_ready = !data_out_valid || data_out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out_valid <= 1'b0;
        end else if (data_in_ready) begin
            data_out_valid <= data_in_valid;
        end
    end

    // Error request rides alongside its own codeword
    always_ff @(posedge clk) begin
        if (data_in_valid && data_in_ready) begin
            codeword_out <= codeword_d;
            err_loc_out  <= err_loc_in;
            err_val_out  <= err_val_in;
        end
    end

endmodule

// ==== hdl/fec_err_inject.sv ====
`include "fec_defines.svh"

module fec_err_inject
    import fec_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,

    input  fec_codeword_u              codeword_in,
    input  logic [`FEC_LOC_WID-1:0]    err_loc_in,
    input  logic [`FEC_SYM_SIZE-1:0]   err_val_in,
    input  logic                       data_in_valid,
    output logic                       data_in_ready,

    output fec_codeword_u              codeword_out,
    output logic [`FEC_LOC_WID-1:0]    err_loc_out,
    output logic                       data_out_valid,
    input  logic                       data_out_ready
);

    // ========================================
    // Channel error
    // ========================================

    fec_codeword_u corrupted;

    // Location 15 hits nothing, word passes clean
    always_comb begin
        corrupted = codeword_in;
        for (int i = 0; i < `FEC_RS_N; i++) begin
            if (int'(err_loc_in) == i) begin
                corrupted.symbols[i] = codeword_in.symbols[i] ^ err_val_in;
            end
        end
    end

    // ========================================
    // Output register
    // ========================================

    assign data_in_ready = !data_out_valid || data_out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out_valid <= 1'b0;
        end else if (data_in_ready) begin
            data_out_valid <= data_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (data_in_valid && data_in_ready) begin
            codeword_out <= corrupted;
            err_loc_out  <= err_loc_in;
        end
    end

endmodule

// ==== hdl/fec_decode.sv ====
`include "fec_defines.svh"

module fec_decode
    import fec_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,

    input  fec_codeword_u              codeword_in,
    input  logic [`FEC_LOC_WID-1:0]    err_loc,
    input  logic                       data_in_valid,
    output logic                       data_in_ready,

    output logic [`FEC_DATA_WID-1:0]   data_out,
    output logic                       data_out_valid,
    input  logic                       data_out_ready
);

    // ========================================
    // Stage one: syndrome at alpha^0
    // ========================================

    logic [`FEC_SYM_SIZE-1:0]   syndrome;

    logic                       s1_valid;
    logic                       s1_ready;
    fec_codeword_u              s1_codeword;
    logic [`FEC_LOC_WID-1:0]    s1_loc;
    logic [`FEC_SYM_SIZE-1:0]   s1_syndrome;

    // c(1) is zero for a valid codeword, so the sum leaves only the error value
    always_comb begin
        syndrome = '0;
        for (int i = 0; i < `FEC_RS_N; i++) begin
            syndrome = syndrome ^ codeword_in.symbols[i];
        end
    end

    logic s2_ready;

    assign s1_ready      = !s1_valid || s2_ready;
    assign data_in_ready = s1_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else if (s1_ready) begin
            s1_valid <= data_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (data_in_valid && s1_ready) begin
            s1_codeword <= codeword_in;
            s1_loc      <= err_loc;
            s1_syndrome <= syndrome;
        end
    end

    // ========================================
    // Stage two: correction at known location
    // ========================================

    fec_codeword_u corrected;

    // Adding the syndrome back cancels the error
    always_comb begin
        corrected = s1_codeword;
        for (int i = 0; i < `FEC_RS_N; i++) begin
            if (int'(s1_loc) == i) begin
                corrected.symbols[i] = s1_codeword.symbols[i] ^ s1_syndrome;
            end
        end
    end

    assign s2_ready = !data_out_valid || data_out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out_valid <= 1'b0;
        end else if (s2_ready) begin
            data_out_valid <= s1_valid;
        end
    end

    // Parity is dropped here, only the data field leaves
    always_ff @(posedge clk) begin
        if (s1_valid && s2_ready) begin
            data_out <= corrected.fields.data;
        end
    end

endmodule

// ==== hdl/fec_chain_top.sv ====
`include "fec_defines.svh"

module fec_chain_top
    import fec_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,

    input  logic [`FEC_DATA_WID-1:0]   data_in,
    input  logic [`FEC_LOC_WID-1:0]    err_loc,
    input  logic [`FEC_SYM_SIZE-1:0]   err_val,
    input  logic                       data_in_valid,
    output logic                       data_in_ready,

    output logic [`FEC_DATA_WID-1:0]   data_out,
    output logic                       data_out_valid,
    input  logic                       data_out_ready
);

    // ========================================
    // Encoder to injector
    // ========================================

    fec_codeword_u              enc_codeword;
    logic [`FEC_LOC_WID-1:0]    enc_err_loc;
    logic [`FEC_SYM_SIZE-1:0]   enc_err_val;
    logic                       enc_valid;
    logic                       enc_ready;

    fec_encode fec_encode_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .data_in        (data_in),
        .err_loc_in     (err_loc),
        .err_val_in     (err_val),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (data_in_ready),
        .codeword_out   (enc_codeword),
        .err_loc_out    (enc_err_loc),
        .err_val_out    (enc_err_val),
        .data_out_valid (enc_valid),
        .data_out_ready (enc_ready)
    );

    // ========================================
    // Injector to decoder
    // ========================================

    fec_codeword_u              chan_codeword;
    logic [`FEC_LOC_WID-1:0]    chan_err_loc;
    logic                       chan_valid;
    logic                       chan_ready;

    fec_err_inject fec_err_inject_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .codeword_in    (enc_codeword),
        .err_loc_in     (enc_err_loc),
        .err_val_in     (enc_err_val),
        .data_in_valid  (enc_valid),
        .data_in_ready  (enc_ready),
        .codeword_out   (chan_codeword),
        .err_loc_out    (chan_err_loc),
        .data_out_valid (chan_valid),
        .data_out_ready (chan_ready)
    );

    // Two registers inside, four in the whole chain
    fec_decode fec_decode_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .codeword_in    (chan_codeword),
        .err_loc        (chan_err_loc),
        .data_in_valid  (chan_valid),
        .data_in_ready  (chan_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

endmodule

// ==== verification/fec_chain_tb.sv ====
`include "fec_defines.svh"

module fec_chain_tb;

    // ========================================
    // Run length
    // ========================================

    localparam int CLEAN_BEATS  = 50;
    localparam int ERROR_BEATS  = 300;
    localparam int SWEEP_BEATS  = 15 * 15;
    localparam int BP_BEATS     = 200;
    localparam int TOTAL_BEATS  = CLEAN_BEATS + ERROR_BEATS + SWEEP_BEATS + BP_BEATS + 1;
    localparam int LIMIT_CYCLES = TOTAL_BEATS * 40 + 200;

    logic                       clk;
    logic                       arst_n;
    logic [`FEC_DATA_WID-1:0]   data_in;
    logic [`FEC_LOC_WID-1:0]    err_loc;
    logic [`FEC_SYM_SIZE-1:0]   err_val;
    logic                       data_in_valid;
    logic                       data_in_ready;
    logic [`FEC_DATA_WID-1:0]   data_out;
    logic                       data_out_valid;
    logic                       data_out_ready = 1'b1;

    logic [`FEC_DATA_WID-1:0]   exp_q[$];
    logic                       bp_mode = 1'b0;
    int                         sent = 0;
    int                         received = 0;
    int                         stall_count = 0;
    int                         cycle_count = 0;
    int                         last_in_cycle = 0;
    int                         last_out_cycle = 0;

    fec_chain_top fec_chain_top_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .data_in        (data_in),
        .err_loc        (err_loc),
        .err_val        (err_val),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (data_in_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================
    // Reference model
    // ========================================

    // Carry-less product, then fold x^6..x^4 with x^4 + x + 1
    function automatic logic [3:0] field_mul(input logic [3:0] a, input logic [3:0] b);
        logic [6:0] p;
        p = '0;
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                p = p ^ ({3'b000, a} << i);
            end
        end
        for (int k = 6; k >= 4; k--) begin
            if (p[k]) begin
                p = p ^ (7'h13 << (k - 4));
            end
        end
        return p[3:0];
    endfunction

    function automatic logic [`FEC_DATA_WID-1:0] ref_decode(
        input logic [`FEC_DATA_WID-1:0] data,
        input logic [3:0]               loc,
        input logic [3:0]               val
    );
        logic [3:0]               gen [0:4];
        logic [3:0]               cw [0:14];
        logic [3:0]               root;
        logic [3:0]               coef;
        logic [3:0]               syn;
        logic [`FEC_DATA_WID-1:0] result;
        // Generator built from its roots alpha^0..alpha^3
        gen[0] = 4'h1;
        for (int i = 1; i < 5; i++) begin
            gen[i] = 4'h0;
        end
        root = 4'h1;
        for (int r = 0; r < 4; r++) begin
            for (int i = 4; i > 0; i--) begin
                gen[i] = gen[i-1] ^ field_mul(gen[i], root);
            end
            gen[0] = field_mul(gen[0], root);
            root = field_mul(root, 4'h2);
        end
        // Long division of data(x) * x^4
        for (int i = 0; i < 15; i++) begin
            cw[i] = (i < 4) ? 4'h0 : data[(i-4)*4 +: 4];
        end
        for (int i = 14; i >= 4; i--) begin
            coef = cw[i];
            for (int j = 0; j < 5; j++) begin
                cw[i-4+j] = cw[i-4+j] ^ field_mul(coef, gen[j]);
            end
        end
        // Division cleared the data part, put it back next to the remainder
        for (int i = 4; i < 15; i++) begin
            cw[i] = data[(i-4)*4 +: 4];
        end
        if (loc < 4'd15) begin
            cw[loc] = cw[loc] ^ val;
        end
        syn = 4'h0;
        for (int i = 0; i < 15; i++) begin
            syn = syn ^ cw[i];
        end
        if (loc < 4'd15) begin
            cw[loc] = cw[loc] ^ syn;
        end
        for (int i = 4; i < 15; i++) begin
            result[(i-4)*4 +: 4] = cw[i];
        end
        return result;
    endfunction

    // ========================================
    // Checking
    // ========================================

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // Output transfers, ready rule and cycle stamps
    always @(posedge clk) begin
        cycle_count++;
        if (data_in_valid && data_in_ready) begin
            last_in_cycle = cycle_count;
        end
        if (arst_n && data_out_ready) begin
            check_value("data_in_ready", 64'(1), 64'(data_in_ready));
        end
        if (!data_in_ready) begin
            stall_count++;
        end
        if (arst_n && data_out_valid && data_out_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("An output beat arrived with no beat outstanding");
            end else begin
                check_value("data_out", 64'(exp_q.pop_front()), 64'(data_out));
                received++;
                last_out_cycle = cycle_count;
            end
        end
    end

    always @(negedge clk) begin
        data_out_ready = bp_mode ? 1'($urandom_range(1, 0)) : 1'b1;
    end

    initial begin
        #(LIMIT_CYCLES * 40);
        abort_run("Timeout, outputs stopped arriving before every beat was checked");
    end

    // ========================================
    // Stimulus
    // ========================================

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_beat(input logic [`FEC_DATA_WID-1:0] d, input logic [3:0] loc,
                             input logic [3:0] val);
        logic [`FEC_DATA_WID-1:0] expected;
        expected = ref_decode(d, loc, val);
        check_value("ref_decode", 64'(d), 64'(expected));
        exp_q.push_back(expected);
        sent++;
        data_in       = d;
        err_loc       = loc;
        err_val       = val;
        data_in_valid = 1'b1;
        @(posedge clk);
        while (!data_in_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        data_in_valid = 1'b0;
    endtask

    function automatic logic [`FEC_DATA_WID-1:0] random_data();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[`FEC_DATA_WID-1:0];
    endfunction

    task automatic wait_drained();
        wait (received == sent);
        @(negedge clk);
    endtask

    initial begin
        arst_n        = 1'b0;
        data_in       = '0;
        err_loc       = '0;
        err_val       = '0;
        data_in_valid = 1'b0;
        void'($urandom(29378));

        repeat (8) begin
            @(negedge clk);
            check_value("data_out_valid", 64'(0), 64'(data_out_valid));
            check_value("data_in_ready", 64'(1), 64'(data_in_ready));
        end
        arst_n = 1'b1;
        @(negedge clk);
        check_value("data_out_valid", 64'(0), 64'(data_out_valid));
        check_value("data_in_ready", 64'(1), 64'(data_in_ready));

        // Zero error value with a random location
        for (int n = 0; n < CLEAN_BEATS; n++) begin
            send_beat(random_data(), 4'($urandom_range(15, 0)), 4'h0);
        end
        for (int n = 0; n < ERROR_BEATS; n++) begin
            send_beat(random_data(), 4'($urandom_range(14, 0)), 4'($urandom_range(15, 1)));
        end
        for (int loc = 0; loc < 15; loc++) begin
            for (int val = 1; val < 16; val++) begin
                send_beat(random_data(), 4'(loc), 4'(val));
            end
        end
        wait_drained();

        // Sink stalls about half the time, source leaves some gaps
        bp_mode     = 1'b1;
        stall_count = 0;
        for (int n = 0; n < BP_BEATS; n++) begin
            if ($urandom_range(3, 0) == 0) begin
                @(negedge clk);
            end
            send_beat(random_data(), 4'($urandom_range(14, 0)), 4'($urandom_range(15, 1)));
        end
        bp_mode = 1'b0;
        wait_drained();
        if (stall_count == 0) begin
            abort_run("data_in_ready never fell while data_out_ready was toggled");
        end

        // Single beat through an idle pipe
        send_beat(random_data(), 4'($urandom_range(14, 0)), 4'($urandom_range(15, 1)));
        wait_drained();
        check_value("latency", 64'(4), 64'(last_out_cycle - last_in_cycle));

        if (exp_q.size() != 0) begin
            abort_run("Expected beats are left over after the last output");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/fec_pkg.sv
hdl/fec_encode.sv
hdl/fec_err_inject.sv
hdl/fec_decode.sv
hdl/fec_chain_top.sv
verification/fec_chain_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module fec_chain_tb -f files.f -o fec_chain_sim
	./obj_dir/fec_chain_sim | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
